/* verification/lsu_tests.txt */
# columns: op amo addr data expected_result expected_fault, all hex
# op 0 none 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 sb 7 sh 8 sw 9 lr a sc b amo
8 0 00000000 11223344 00000000 0
6 0 00000001 000000ab 00000001 0
7 0 00000002 0000f00d 00000002 0
5 0 00000000 00000000 f00dab44 0
1 0 00000001 00000000 ffffffab 0
2 0 00000001 00000000 000000ab 0
3 0 00000002 00000000 fffff00d 0
4 0 00000002 00000000 0000f00d 0
1 0 00000000 00000000 00000044 0
3 0 00000000 00000000 ffffab44 0
# amo 0 swap 1 add 2 xor 3 and 4 or 5 min 6 max 7 minu 8 maxu, old value returned
8 0 00000010 00000005 00000010 0
b 0 00000010 00000007 00000005 0
b 1 00000010 00000003 00000007 0
b 2 00000010 0000000f 0000000a 0
b 3 00000010 00000006 00000005 0
b 4 00000010 00000003 00000004 0
b 5 00000010 fffffffe 00000007 0
b 6 00000010 00000003 fffffffe 0
b 7 00000010 fffffff0 00000003 0
b 8 00000010 fffffff0 00000003 0
5 0 00000010 00000000 fffffff0 0
# lr and sc, reservation lost on a plain store and on another address
9 0 00000020 00000000 00000000 0
a 0 00000020 12345678 00000000 0
5 0 00000020 00000000 12345678 0
a 0 00000020 0badbeef 00000001 0
5 0 00000020 00000000 12345678 0
9 0 00000020 00000000 12345678 0
8 0 00000024 00000055 00000024 0
a 0 00000020 0000aaaa 00000001 0
5 0 00000020 00000000 12345678 0
9 0 00000020 00000000 12345678 0
a 0 00000028 0000bbbb 00000001 0
5 0 00000028 00000000 00000000 0
# misaligned atomics fault, none passes the address back
b 1 00000022 00000001 00000000 1
9 0 00000021 00000000 00000000 1
a 0 00000023 00000099 00000000 1
5 0 00000020 00000000 12345678 0
0 0 deadbeec 00000000 deadbeec 0

/* list.f */
+incdir+hdl
hdl/lsu_bus_pkg.sv
hdl/lsu_op_pkg.sv
hdl/lsu_lane_align.sv
hdl/amo_alu.sv
hdl/amo_engine.sv
hdl/lsu_port_ctrl.sv
hdl/lsu_top.sv
verification/lsu_sva.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

/* Makefile */
# Verilator build and run of the LSU testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module lsu_tb -Mdir obj_dir -o lsu_sim

run: compile
	./obj_dir/lsu_sim | tee $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb
    import lsu_bus_pkg::*, lsu_op_pkg::*;
();

    // cycles any single wait may take
    localparam int WAIT_LIMIT = 200;

    logic     clk;
    logic     rst;
    logic     req;
    lsu_req_t req_data;
    logic     ack;
    lsu_rsp_t rsp;
    logic     mem_req;
    mem_cmd_t mem_cmd;
    logic     mem_ack;
    word_t    mem_rdata;
    word_t    exp_result;
    logic     exp_fault;
    word_t    mem [16];
    int       err_count;
    int       check_count;
    int       sent;
    int       timeouts;
    logic     mem_stuck;
    logic     file_ok;

    lsu_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .req_data_i  (req_data),
        .ack_o       (ack),
        .rsp_o       (rsp),
        .mem_req_o   (mem_req),
        .mem_cmd_o   (mem_cmd),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    lsu_checker u_chk (
        .clk           (clk),
        .rst           (rst),
        .ack_i         (ack),
        .rsp_i         (rsp),
        .exp_result_i  (exp_result),
        .exp_fault_i   (exp_fault),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    // handshake and calc rules, seen from inside the controller
    bind lsu_port_ctrl lsu_sva u_sva (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .ack_i          (ack_o),
        .mem_req_i      (mem_req_o),
        .mem_ack_i      (mem_ack_i),
        .mem_cmd_i      (mem_cmd_o),
        .access_valid_i (access_valid_i),
        .access_cmd_i   (access_cmd_i),
        .access_done_i  (access_done_o),
        .latched_req_i  (latched_req_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one request, then the four-phase return
    task automatic run_request(input logic [31:0] op, input logic [31:0] amo,
                               input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] res, input logic [31:0] fault,
                               output logic stuck);
        int n;
        stuck         = 1'b0;
        req_data.op   = mem_op_e'(op[3:0]);
        req_data.amo  = amo_op_e'(amo[3:0]);
        req_data.addr = addr;
        req_data.data = data;
        exp_result    = res;
        exp_fault     = fault[0];
        req           = 1'b1;
        sent++;
        n = 0;
        while (!ack && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ack) begin
            $display("timeout: no ack_o for request %0d at time %0t", sent, $time);
            timeouts++;
            stuck = 1'b1;
        end else begin
            req = 1'b0;
            n = 0;
            while (ack && n < WAIT_LIMIT) begin
                @(posedge clk);
                #2;
                n++;
            end
            if (ack) begin
                $display("timeout: ack_o stayed high after req_i fell, request %0d", sent);
                timeouts++;
                stuck = 1'b1;
            end
        end
    endtask

    // memory model, 16 words, random wait before each ack
    initial begin : mem_model
        int unsigned delay;
        int          n;
        logic [3:0]  idx;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        mem_stuck = 1'b0;
        void'($urandom(88));
        for (int i = 0; i < 16; i++) begin
            mem[i] = '0;
        end
        forever begin
            @(posedge clk);
            #2;
            if (mem_req && !mem_ack) begin
                delay = $urandom % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                idx = mem_cmd.addr[5:2];
                if (mem_cmd.we) begin
                    // only enabled lanes change
                    for (int b = 0; b < 4; b++) begin
                        if (mem_cmd.mask[b]) begin
                            mem[idx][8*b +: 8] = mem_cmd.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    mem_rdata = mem[idx];
                end
                mem_ack = 1'b1;
                n = 0;
                while (mem_req && n < WAIT_LIMIT) begin
                    @(posedge clk);
                    #2;
                    n++;
                end
                if (mem_req) begin
                    $display("timeout: mem_req_o never dropped after mem_ack_i");
                    mem_stuck = 1'b1;
                end
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_amo;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_res;
        logic [31:0] f_fault;
        logic        timed_out;
        rst        = 1'b1;
        req        = 1'b0;
        req_data   = '0;
        exp_result = '0;
        exp_fault  = 1'b0;
        sent       = 0;
        timeouts   = 0;
        timed_out  = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("verification/lsu_tests.txt", "r");
        file_ok = fd != 0;
        if (!file_ok) begin
            $display("could not open verification/lsu_tests.txt");
        end
        while (file_ok && !timed_out && !$feof(fd)) begin
            n = $fgets(line, fd);
            // skip comments and blank lines
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h",
                            f_op, f_amo, f_addr, f_data, f_res, f_fault);
                if (n == 6) begin
                    run_request(f_op, f_amo, f_addr, f_data, f_res, f_fault, timed_out);
                end
            end
        end
        if (file_ok) begin
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        if (check_count != sent) begin
            $display("only %0d of %0d requests got a response check", check_count, sent);
        end
        $display("closing: %0d requests, %0d checked, %0d errors, %0d timeouts",
                 sent, check_count, err_count, timeouts);
        if (file_ok && sent > 0 && err_count == 0 && timeouts == 0 && !mem_stuck &&
            check_count == sent) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verification/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ack_i,
    input  lsu_rsp_t rsp_i,
    input  word_t    exp_result_i,
    input  logic     exp_fault_i,
    output int       err_count_o,
    output int       check_count_o
);

    int   errors = 0;
    int   checks = 0;
    logic ack_prev = 1'b0;

    // sampled mid-cycle, all DUT outputs settled
    always @(negedge clk) begin
        if (rst) begin
            ack_prev = 1'b0;
        end else begin
            // one compare per request, on the rising ack
            if (ack_i && !ack_prev) begin
                checks++;
                if (rsp_i.result !== exp_result_i) begin
                    $display("ERROR time %0t: rsp_o.result got %h expected %h",
                             $time, rsp_i.result, exp_result_i);
                    errors++;
                end
                if (rsp_i.fault !== exp_fault_i) begin
                    $display("ERROR time %0t: rsp_o.fault got %b expected %b",
                             $time, rsp_i.fault, exp_fault_i);
                    errors++;
                end
            end
            ack_prev = ack_i;
        end
    end

    assign err_count_o   = errors;
    assign check_count_o = checks;

endmodule

/* verification/lsu_sva.sv */
`timescale 1ns/1ps

module lsu_sva
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req_i,
    input logic     ack_i,
    input logic     mem_req_i,
    input logic     mem_ack_i,
    input mem_cmd_t mem_cmd_i,
    input logic     access_valid_i,
    input mem_cmd_t access_cmd_i,
    input logic     access_done_i,
    input lsu_req_t latched_req_i
);

    logic amo_read_done;

    // read half of a read-modify-write just finished, engine goes to calc
    assign amo_read_done = access_done_i && !access_cmd_i.we &&
                           (latched_req_i.op == MEMOP_AMO);

    // command frozen while the memory has not answered
    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_i && !mem_ack_i |=> $stable(mem_cmd_i))
        else $error("mem_cmd_o changed while waiting for mem_ack_i");

    // return to zero before the next memory request
    req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_i) |-> !$past(mem_ack_i))
        else $error("mem_req_o rose while mem_ack_i was still high");

    // pipeline side, ack only drops once req is gone
    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack_i) |-> !$past(req_i))
        else $error("ack_o fell while req_i was still high");

    // calc is a single cycle with no access
    calc_gap: assert property (@(posedge clk) disable iff (rst)
        $past(amo_read_done) |-> !access_valid_i)
        else $error("engine requested an access during calc");

    calc_one_cycle: assert property (@(posedge clk) disable iff (rst)
        $past(amo_read_done, 2) |-> access_valid_i && access_cmd_i.we)
        else $error("engine did not start the write one cycle after calc");

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_i,
    input  lsu_req_t req_data_i,
    output logic     ack_o,
    output lsu_rsp_t rsp_o,
    output logic     mem_req_o,
    output mem_cmd_t mem_cmd_o,
    input  logic     mem_ack_i,
    input  word_t    mem_rdata_i
);

    lsu_req_t latched_req;
    mask_t    align_mask;
    word_t    align_wdata;
    word_t    align_load;
    logic     amo_start;
    logic     plain_store_done;
    logic     access_valid;
    mem_cmd_t access_cmd;
    logic     access_done;
    word_t    access_rdata;
    logic     amo_done;
    lsu_rsp_t amo_rsp;

    // plain path, fed from the held request
    lsu_lane_align u_align (
        .op_i         (latched_req.op),
        .addr_lo_i    (latched_req.addr[1:0]),
        .store_data_i (latched_req.data),
        .mem_rdata_i  (mem_rdata_i),
        .mask_o       (align_mask),
        .wdata_o      (align_wdata),
        .load_data_o  (align_load)
    );

    // LR, SC and read-modify-write path
    amo_engine u_engine (
        .clk                (clk),
        .rst                (rst),
        .amo_start_i        (amo_start),
        .req_i              (latched_req),
        .plain_store_done_i (plain_store_done),
        .access_valid_o     (access_valid),
        .access_cmd_o       (access_cmd),
        .access_done_i      (access_done),
        .access_rdata_i     (access_rdata),
        .amo_done_o         (amo_done),
        .amo_rsp_o          (amo_rsp)
    );

    lsu_port_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .req_i              (req_i),
        .req_data_i         (req_data_i),
        .ack_o              (ack_o),
        .rsp_o              (rsp_o),
        .align_mask_i       (align_mask),
        .align_wdata_i      (align_wdata),
        .align_load_i       (align_load),
        .amo_start_o        (amo_start),
        .latched_req_o      (latched_req),
        .plain_store_done_o (plain_store_done),
        .access_valid_i     (access_valid),
        .access_cmd_i       (access_cmd),
        .access_done_o      (access_done),
        .access_rdata_o     (access_rdata),
        .amo_done_i         (amo_done),
        .amo_rsp_i          (amo_rsp),
        .mem_req_o          (mem_req_o),
        .mem_cmd_o          (mem_cmd_o),
        .mem_ack_i          (mem_ack_i),
        .mem_rdata_i        (mem_rdata_i)
    );

endmodule

/* hdl/lsu_port_ctrl.sv */
`timescale 1ns/1ps

module lsu_port_ctrl
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_i,
    input  lsu_req_t req_data_i,
    output logic     ack_o,
    output lsu_rsp_t rsp_o,
    input  mask_t    align_mask_i,
    input  word_t    align_wdata_i,
    input  word_t    align_load_i,
    output logic     amo_start_o,
    output lsu_req_t latched_req_o,
    output logic     plain_store_done_o,
    input  logic     access_valid_i,
    input  mem_cmd_t access_cmd_i,
    output logic     access_done_o,
    output word_t    access_rdata_o,
    input  logic     amo_done_i,
    input  lsu_rsp_t amo_rsp_i,
    output logic     mem_req_o,
    output mem_cmd_t mem_cmd_o,
    input  logic     mem_ack_i,
    input  word_t    mem_rdata_i
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_PLAIN,
        P_AMO,
        P_RESP
    } port_state_e;

    port_state_e state;
    port_state_e state_nxt;
    lsu_req_t    req_q;
    lsu_rsp_t    rsp_q;
    mem_cmd_t    mem_cmd_q;
    mem_cmd_t    cmd_sel;
    logic        mem_req_q;
    logic        amo_start_q;
    logic        accept;
    logic        acc_plain;
    logic        acc_atomic;
    logic        req_store;
    logic        mem_issue;
    logic        mem_fin;

    // new request only once the last one has been returned
    assign accept = (state == P_IDLE) && req_i;

    // path chosen once, at acceptance
    always_comb begin
        acc_plain  = 1'b0;
        acc_atomic = 1'b0;
        case (req_data_i.op)
            MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW,
            MEMOP_SB, MEMOP_SH, MEMOP_SW: acc_plain = 1'b1;
            MEMOP_LR_W, MEMOP_SC_W, MEMOP_AMO: acc_atomic = 1'b1;
            default: acc_plain = 1'b0;
        endcase
    end

    assign req_store = req_q.op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW};

    // memory side, one access at a time
    assign mem_fin   = mem_req_q && mem_ack_i;
    assign mem_issue = !mem_req_q && !mem_ack_i &&
                       ((state == P_PLAIN) || (state == P_AMO && access_valid_i));

    // plain command built from the aligner
    always_comb begin
        if (state == P_PLAIN) begin
            cmd_sel.addr  = {req_q.addr[31:2], 2'b00};
            cmd_sel.we    = req_store;
            cmd_sel.mask  = align_mask_i;
            cmd_sel.wdata = align_wdata_i;
        end else begin
            cmd_sel = access_cmd_i;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            P_IDLE: begin
                if (req_i) begin
                    if (acc_plain) begin
                        state_nxt = P_PLAIN;
                    end else if (acc_atomic) begin
                        state_nxt = P_AMO;
                    end else begin
                        state_nxt = P_RESP;
                    end
                end
            end
            P_PLAIN: state_nxt = mem_fin ? P_RESP : P_PLAIN;
            P_AMO:   state_nxt = amo_done_i ? P_RESP : P_AMO;
            // four-phase return
            P_RESP:  state_nxt = req_i ? P_RESP : P_IDLE;
            default: state_nxt = P_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= P_IDLE;
            mem_req_q   <= 1'b0;
            amo_start_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // engine sees the latched request one cycle later
            amo_start_q <= accept && acc_atomic;
            if (mem_issue) begin
                mem_req_q <= 1'b1;
            end else if (mem_fin) begin
                mem_req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_data_i;
        end
        // no memory op, hand back the ALU value
        if (accept && !acc_plain && !acc_atomic) begin
            rsp_q.result <= req_data_i.addr;
            rsp_q.fault  <= 1'b0;
        end
        // stores pass the address back like the none case
        if (state == P_PLAIN && mem_fin) begin
            rsp_q.result <= req_store ? req_q.addr : align_load_i;
            rsp_q.fault  <= 1'b0;
        end
        if (state == P_AMO && amo_done_i) begin
            rsp_q <= amo_rsp_i;
        end
        if (mem_issue) begin
            mem_cmd_q <= cmd_sel;
        end
    end

    assign ack_o              = state == P_RESP;
    assign rsp_o              = rsp_q;
    assign amo_start_o        = amo_start_q;
    assign latched_req_o      = req_q;
    assign plain_store_done_o = (state == P_PLAIN) && mem_fin && req_store;
    // engine takes the word on the same edge mem_req drops
    assign access_done_o      = (state == P_AMO) && mem_fin;
    assign access_rdata_o     = mem_rdata_i;
    assign mem_req_o          = mem_req_q;
    assign mem_cmd_o          = mem_cmd_q;

endmodule

/* hdl/amo_engine.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module amo_engine
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     amo_start_i,
    input  lsu_req_t req_i,
    input  logic     plain_store_done_i,
    output logic     access_valid_o,
    output mem_cmd_t access_cmd_o,
    input  logic     access_done_i,
    input  word_t    access_rdata_i,
    output logic     amo_done_o,
    output lsu_rsp_t amo_rsp_o
);

    amo_state_e state;
    amo_state_e state_nxt;
    lsu_req_t   req_q;
    lsu_rsp_t   rsp_q;
    word_t      old_q;
    word_t      new_q;
    word_t      alu_res;
    addr_t      resv_addr;
    logic       resv_valid;
    logic       start;
    logic       misaligned;
    logic       sc_hit;
    logic       is_lr_q;
    logic       is_sc_q;
    logic       set_resv;
    logic       clr_resv;

    amo_alu u_alu (
        .op_i      (req_q.amo),
        .mem_val_i (old_q),
        .rs2_i     (req_q.data),
        .result_o  (alu_res)
    );

    assign start      = (state == AMO_IDLE) && amo_start_i;
    // atomics need a word address
    assign misaligned = req_i.addr[1:0] != 2'b00;
    assign sc_hit     = resv_valid && (resv_addr == req_i.addr);
    assign is_lr_q    = req_q.op == MEMOP_LR_W;
    assign is_sc_q    = req_q.op == MEMOP_SC_W;

    // reservation taken when the LR read returns
    assign set_resv = (state == AMO_LOAD) && access_done_i && is_lr_q;
    // SC and AMO drop it whether they store or not
    assign clr_resv = (start && !misaligned &&
                       (req_i.op == MEMOP_SC_W || req_i.op == MEMOP_AMO)) ||
                      (plain_store_done_i && `LSU_PLAIN_STORE_CLEARS_RESV);

    always_comb begin
        state_nxt = state;
        case (state)
            AMO_IDLE: begin
                if (amo_start_i) begin
                    if (misaligned) begin
                        state_nxt = AMO_DONE;
                    end else if (req_i.op == MEMOP_LR_W || req_i.op == MEMOP_AMO) begin
                        state_nxt = AMO_LOAD;
                    end else if (req_i.op == MEMOP_SC_W && sc_hit) begin
                        state_nxt = AMO_STORE;
                    end else begin
                        // failed SC, no memory access
                        state_nxt = AMO_DONE;
                    end
                end
            end
            AMO_LOAD: begin
                if (access_done_i) begin
                    state_nxt = is_lr_q ? AMO_DONE : AMO_CALC;
                end
            end
            // single cycle for the ALU result
            AMO_CALC:  state_nxt = AMO_STORE;
            AMO_STORE: begin
                if (access_done_i) begin
                    state_nxt = AMO_DONE;
                end
            end
            AMO_DONE:  state_nxt = AMO_IDLE;
            default:   state_nxt = AMO_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= AMO_IDLE;
            resv_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (set_resv) begin
                resv_valid <= 1'b1;
            end else if (clr_resv) begin
                resv_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q        <= req_i;
            rsp_q.fault  <= misaligned;
            // 1 only for an SC that misses the reservation
            rsp_q.result <= (req_i.op == MEMOP_SC_W && !misaligned && !sc_hit) ?
                            word_t'(1) : '0;
        end
        if (state == AMO_LOAD && access_done_i) begin
            old_q <= access_rdata_i;
            if (is_lr_q) begin
                rsp_q.result <= access_rdata_i;
            end
        end
        if (set_resv) begin
            resv_addr <= req_q.addr;
        end
        if (state == AMO_CALC) begin
            new_q <= alu_res;
        end
        // SC success gives 0, amo gives the old value
        if (state == AMO_STORE && access_done_i) begin
            rsp_q.result <= is_sc_q ? '0 : old_q;
        end
    end

    assign access_valid_o     = (state == AMO_LOAD) || (state == AMO_STORE);
    assign access_cmd_o.addr  = req_q.addr;
    assign access_cmd_o.we    = state == AMO_STORE;
    // whole word both ways
    assign access_cmd_o.mask  = '1;
    assign access_cmd_o.wdata = is_sc_q ? req_q.data : new_q;

    assign amo_done_o = state == AMO_DONE;
    assign amo_rsp_o  = rsp_q;

endmodule

/* hdl/amo_alu.sv */
`timescale 1ns/1ps

module amo_alu
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  amo_op_e op_i,
    input  word_t   mem_val_i,
    input  word_t   rs2_i,
    output word_t   result_o
);

    logic s_lt;
    logic u_lt;

    // old value below rs2, two's complement order
    assign s_lt = $signed(mem_val_i) < $signed(rs2_i);
    // same, plain magnitude order
    assign u_lt = mem_val_i < rs2_i;

    // new memory value
    always_comb begin
        case (op_i)
            AMOOP_SWAP: result_o = rs2_i;
            AMOOP_ADD:  result_o = mem_val_i + rs2_i;
            AMOOP_XOR:  result_o = mem_val_i ^ rs2_i;
            AMOOP_AND:  result_o = mem_val_i & rs2_i;
            AMOOP_OR:   result_o = mem_val_i | rs2_i;
            AMOOP_MIN:  result_o = s_lt ? mem_val_i : rs2_i;
            AMOOP_MAX:  result_o = s_lt ? rs2_i : mem_val_i;
            AMOOP_MINU: result_o = u_lt ? mem_val_i : rs2_i;
            AMOOP_MAXU: result_o = u_lt ? rs2_i : mem_val_i;
            // unknown code behaves like swap
            default:    result_o = rs2_i;
        endcase
    end

endmodule

/* hdl/lsu_lane_align.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_lane_align
    import lsu_bus_pkg::*, lsu_op_pkg::*;
(
    input  mem_op_e    op_i,
    input  logic [1:0] addr_lo_i,
    input  word_t      store_data_i,
    input  word_t      mem_rdata_i,
    output mask_t      mask_o,
    output word_t      wdata_o,
    output word_t      load_data_o
);

    mask_t      size_mask;
    logic [4:0] lane_shift;
    word_t      rdata_sh;

    // byte offset as a bit offset
    assign lane_shift = {addr_lo_i, 3'b000};

    // access size as lanes from lane 0
    always_comb begin
        case (op_i)
            MEMOP_LB, MEMOP_LBU, MEMOP_SB: size_mask = 4'b0001;
            MEMOP_LH, MEMOP_LHU, MEMOP_SH: size_mask = 4'b0011;
            MEMOP_LW, MEMOP_SW:            size_mask = 4'b1111;
            default:                       size_mask = 4'b0000;
        endcase
    end

    // moved up to the addressed lanes
    assign mask_o = size_mask << addr_lo_i;

    // store data follows the mask
    assign wdata_o = store_data_i << lane_shift;

    // addressed lanes brought down to bit 0
    assign rdata_sh = mem_rdata_i >> lane_shift;

    always_comb begin
        case (op_i)
            MEMOP_LB: begin
                load_data_o = {{(`LSU_XLEN-8){rdata_sh[7]}}, rdata_sh[7:0]};
            end
            MEMOP_LBU: begin
                load_data_o = {{(`LSU_XLEN-8){1'b0}}, rdata_sh[7:0]};
            end
            MEMOP_LH: begin
                load_data_o = {{(`LSU_XLEN-16){rdata_sh[15]}}, rdata_sh[15:0]};
            end
            MEMOP_LHU: begin
                load_data_o = {{(`LSU_XLEN-16){1'b0}}, rdata_sh[15:0]};
            end
            // lw and everything else see the raw word
            default: begin
                load_data_o = mem_rdata_i;
            end
        endcase
    end

endmodule

/* hdl/lsu_op_pkg.sv */
`include "lsu_defs.svh"

package lsu_op_pkg;

    import lsu_bus_pkg::*;

    // memory operation from the pipeline
    typedef enum logic [`LSU_MEMOP_W-1:0] {
        MEMOP_NONE = 4'd0,
        MEMOP_LB   = 4'd1,
        MEMOP_LBU  = 4'd2,
        MEMOP_LH   = 4'd3,
        MEMOP_LHU  = 4'd4,
        MEMOP_LW   = 4'd5,
        MEMOP_SB   = 4'd6,
        MEMOP_SH   = 4'd7,
        MEMOP_SW   = 4'd8,
        MEMOP_LR_W = 4'd9,
        MEMOP_SC_W = 4'd10,
        MEMOP_AMO  = 4'd11
    } mem_op_e;

    // read-modify-write kind, only looked at with MEMOP_AMO
    typedef enum logic [`LSU_AMOOP_W-1:0] {
        AMOOP_SWAP = 4'd0,
        AMOOP_ADD  = 4'd1,
        AMOOP_XOR  = 4'd2,
        AMOOP_AND  = 4'd3,
        AMOOP_OR   = 4'd4,
        AMOOP_MIN  = 4'd5,
        AMOOP_MAX  = 4'd6,
        AMOOP_MINU = 4'd7,
        AMOOP_MAXU = 4'd8
    } amo_op_e;

    // pipeline request, 72 bits
    // addr is the ALU result, data is rs2
    typedef struct packed {
        mem_op_e op;
        amo_op_e amo;
        addr_t   addr;
        word_t   data;
    } lsu_req_t;

    // response, 33 bits
    typedef struct packed {
        word_t result;
        logic  fault;
    } lsu_rsp_t;

    // atomic engine sequence
    typedef enum logic [2:0] {
        AMO_IDLE,
        AMO_LOAD,
        AMO_CALC,
        AMO_STORE,
        AMO_DONE
    } amo_state_e;

endpackage

/* hdl/lsu_bus_pkg.sv */
`include "lsu_defs.svh"

package lsu_bus_pkg;

    // one data word on the memory bus
    typedef logic [`LSU_XLEN-1:0] word_t;

    // byte address, word aligned on the bus side
    typedef logic [`LSU_XLEN-1:0] addr_t;

    // per-lane write enable
    typedef logic [`LSU_LANES-1:0] mask_t;

    // memory command, 69 bits
    // held stable by the controller for a whole handshake
    typedef struct packed {
        addr_t addr;
        logic  we;
        mask_t mask;
        word_t wdata;
    } mem_cmd_t;

endpackage

/* hdl/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path width in bits
`define LSU_XLEN 32

// byte lanes in one memory word
`define LSU_LANES 4

// code widths of the memory op and the amo op
`define LSU_MEMOP_W 4
`define LSU_AMOOP_W 4

// any completed plain store drops the LR reservation
`define LSU_PLAIN_STORE_CLEARS_RESV 1'b1

`endif
